// File: decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define INSTR_W     32

// Fixed RV32I encoding fields
`define OPCODE_W    7
`define RD_LSB      7
`define FUNCT3_LSB  12
`define FUNCT3_W    3
`define RS1_LSB     15
`define RS2_LSB     20
`define FUNCT7_LSB  25
`define FUNCT7_W    7

`endif

// File: decodePkg.sv
`default_nettype none

package decodePkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        R_TYPE = 7'b0110011,
        I_TYPE = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcodeT;

    // ALU operations, branch compares in the upper half
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b0001,
        AND  = 4'b0010,
        OR   = 4'b0011,
        XOR  = 4'b0100,
        SLL  = 4'b0101,
        SRL  = 4'b0110,
        SRA  = 4'b0111,
        SLT  = 4'b1000,
        SLTU = 4'b1001,
        BEQ  = 4'b1010,
        BNE  = 4'b1011,
        BLT  = 4'b1100,
        BGE  = 4'b1101,
        BLTU = 4'b1110,
        BGEU = 4'b1111
    } aluOpT;

    typedef enum logic [1:0] {
        MEM_DISABLE   = 2'b00,
        MEM_READ_SEXT = 2'b01,
        MEM_READ_ZEXT = 2'b10,
        MEM_WRITE     = 2'b11
    } memOpT;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE     = 2'b00,
        HALFWORD = 2'b01,
        WORD     = 2'b10
    } memSizeT;

    typedef enum logic [1:0] {
        SEL_B_RS2  = 2'b00,
        SEL_B_IMM  = 2'b01,
        SEL_B_FOUR = 2'b10  // Link address for jumps
    } selBT;

    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_SHAMT = 3'd2,
        IMM_S     = 3'd3,
        IMM_B     = 3'd4,
        IMM_U     = 3'd5,
        IMM_J     = 3'd6
    } immFmtT;

endpackage

`default_nettype wire

// File: immGen.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module immGen (
    input  wire logic [`INSTR_W-1:0] instruction,
    input  decodePkg::immFmtT        immFmt,
    output logic [`XLEN-1:0]         imm
);

    import decodePkg::*;

    logic signBit;

    assign signBit = instruction[31];  // Always the sign in RV32I

    always_comb begin
        case (immFmt)
            IMM_I: begin
                imm = {{(`XLEN-12){signBit}}, instruction[31:20]};
            end
            IMM_SHAMT: begin
                imm = {{(`XLEN-5){1'b0}}, instruction[24:20]};  // Zero-extended shamt
            end
            IMM_S: begin
                imm = {{(`XLEN-12){signBit}}, instruction[31:25], instruction[11:7]};
            end
            IMM_B: begin
                imm = {{(`XLEN-13){signBit}}, signBit, instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            IMM_U: begin
                // Upper 20 bits in place, no further shift
                imm = {instruction[31:12], {(`XLEN-20){1'b0}}};
            end
            IMM_J: begin
                imm = {{(`XLEN-21){signBit}}, signBit, instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: ctrlDecode.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module ctrlDecode (
    input  wire logic [`INSTR_W-1:0]  instruction,
    output logic [`REG_ADDR_W-1:0]    rs1,
    output logic [`REG_ADDR_W-1:0]    rs2,
    output logic [`REG_ADDR_W-1:0]    rd,
    output decodePkg::aluOpT          aluOp,
    output logic                      selA,     // PC when high
    output decodePkg::selBT           selB,
    output logic                      aluToReg,
    output decodePkg::memOpT          memOp,
    output decodePkg::memSizeT        memSize,
    output logic                      branch,
    output logic                      jal,
    output logic                      jalr,
    output decodePkg::immFmtT         immFmt
);

    import decodePkg::*;

    opcodeT                  opcode;
    logic [`FUNCT3_W-1:0]    funct3;
    logic [`FUNCT7_W-1:0]    funct7;
    logic [`REG_ADDR_W-1:0]  rdField;
    logic [`REG_ADDR_W-1:0]  rs1Field;
    logic [`REG_ADDR_W-1:0]  rs2Field;
    logic                    rLegal;
    logic                    iLegal;
    logic                    altOp;     // Bit 30 selects SUB and SRA

    assign opcode   = opcodeT'(instruction[`OPCODE_W-1:0]);
    assign funct3   = instruction[`FUNCT3_LSB +: `FUNCT3_W];
    assign funct7   = instruction[`FUNCT7_LSB +: `FUNCT7_W];
    assign rdField  = instruction[`RD_LSB +: `REG_ADDR_W];
    assign rs1Field = instruction[`RS1_LSB +: `REG_ADDR_W];
    assign rs2Field = instruction[`RS2_LSB +: `REG_ADDR_W];
    assign altOp    = (funct7 == 7'b0100000);

    // SUB and SRA are the only R-type ops with bit 30 set
    assign rLegal = (funct7 == 7'b0000000) ||
                    (altOp && (funct3 == 3'b000 || funct3 == 3'b101));

    // Shift immediates carry funct7 in the upper imm bits
    assign iLegal = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                    (funct3 == 3'b101) ? (funct7 == 7'b0000000 || altOp) : 1'b1;

    function automatic aluOpT aluFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  aluFunct = alt ? SUB : ADD;
            3'b001:  aluFunct = SLL;
            3'b010:  aluFunct = SLT;
            3'b011:  aluFunct = SLTU;
            3'b100:  aluFunct = XOR;
            3'b101:  aluFunct = alt ? SRA : SRL;
            3'b110:  aluFunct = OR;
            default: aluFunct = AND;
        endcase
    endfunction

    always_comb begin
        // Bubble unless a legal encoding matches below
        rs1      = '0;
        rs2      = '0;
        rd       = '0;
        aluOp    = ADD;
        selA     = 1'b0;
        selB     = SEL_B_RS2;
        aluToReg = 1'b0;
        memOp    = MEM_DISABLE;
        memSize  = BYTE;
        branch   = 1'b0;
        jal      = 1'b0;
        jalr     = 1'b0;
        immFmt   = IMM_NONE;

        case (opcode)
            R_TYPE: if (rLegal) begin
                rs1      = rs1Field;
                rs2      = rs2Field;
                rd       = rdField;
                aluOp    = aluFunct(funct3, altOp);
                aluToReg = 1'b1;
            end
            I_TYPE: if (iLegal) begin
                rs1      = rs1Field;
                rd       = rdField;
                aluOp    = aluFunct(funct3, altOp && funct3 == 3'b101);
                selB     = SEL_B_IMM;
                aluToReg = 1'b1;
                immFmt   = (funct3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I;
            end
            LOAD: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                rs1     = rs1Field;
                rd      = rdField;
                selB    = SEL_B_IMM;        // Address is rs1 + imm
                memOp   = funct3[2] ? MEM_READ_ZEXT : MEM_READ_SEXT;
                memSize = memSizeT'(funct3[1:0]);
                immFmt  = IMM_I;
            end
            STORE: if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
                rs1     = rs1Field;
                rs2     = rs2Field;
                selB    = SEL_B_IMM;
                memOp   = MEM_WRITE;
                memSize = memSizeT'(funct3[1:0]);
                immFmt  = IMM_S;
            end
            BRANCH: if (funct3[2:1] != 2'b01) begin
                rs1    = rs1Field;
                rs2    = rs2Field;
                branch = 1'b1;
                immFmt = IMM_B;
                case (funct3)
                    3'b000:  aluOp = BEQ;
                    3'b001:  aluOp = BNE;
                    3'b100:  aluOp = BLT;
                    3'b101:  aluOp = BGE;
                    3'b110:  aluOp = BLTU;
                    default: aluOp = BGEU;
                endcase
            end
            JAL: begin
                rd       = rdField;
                selA     = 1'b1;            // PC + 4 into rd
                selB     = SEL_B_FOUR;
                aluToReg = 1'b1;
                jal      = 1'b1;
                immFmt   = IMM_J;
            end
            JALR: if (funct3 == 3'b000) begin
                rs1      = rs1Field;        // Target base
                rd       = rdField;
                selA     = 1'b1;
                selB     = SEL_B_FOUR;
                aluToReg = 1'b1;
                jalr     = 1'b1;
                immFmt   = IMM_I;
            end
            LUI, AUIPC: begin
                rd       = rdField;
                selA     = (opcode == AUIPC);
                selB     = SEL_B_IMM;
                aluToReg = 1'b1;
                immFmt   = IMM_U;
            end
            default: begin
                // FENCE, SYSTEM and unknown opcodes stay a bubble
                immFmt = IMM_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: decodeReg.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module decodeReg (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   stall,
    input  wire logic                   flush,
    input  wire logic [`XLEN-1:0]       pcIn,
    input  wire logic [`REG_ADDR_W-1:0] rs1Next,
    input  wire logic [`REG_ADDR_W-1:0] rs2Next,
    input  wire logic [`REG_ADDR_W-1:0] rdNext,
    input  wire logic [`XLEN-1:0]       immNext,
    input  decodePkg::aluOpT            aluOpNext,
    input  wire logic                   selANext,
    input  decodePkg::selBT             selBNext,
    input  wire logic                   aluToRegNext,
    input  decodePkg::memOpT            memOpNext,
    input  decodePkg::memSizeT          memSizeNext,
    input  wire logic                   branchNext,
    input  wire logic                   jalNext,
    input  wire logic                   jalrNext,
    output logic [`REG_ADDR_W-1:0]      rs1,
    output logic [`REG_ADDR_W-1:0]      rs2,
    output logic [`REG_ADDR_W-1:0]      rd,
    output logic [`XLEN-1:0]            imm,
    output decodePkg::aluOpT            aluOp,
    output logic                        selA,
    output decodePkg::selBT             selB,
    output logic                        aluToReg,
    output decodePkg::memOpT            memOp,
    output decodePkg::memSizeT          memSize,
    output logic                        branch,
    output logic                        jal,
    output logic                        jalr,
    output logic [`XLEN-1:0]            pc
);

    import decodePkg::*;

    logic ignoreNext;   // Discard the next non-stalled instruction
    logic update;
    logic clearOut;

    // Reset and flush override stall
    assign update   = !rstN || flush || !stall;
    assign clearOut = !rstN || flush || ignoreNext;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ignoreNext <= 1'b0;
        end else if (flush) begin
            ignoreNext <= 1'b1;
        end else if (!stall) begin
            ignoreNext <= 1'b0;     // Consumed by this edge
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            rs1      <= clearOut ? '0          : rs1Next;
            rs2      <= clearOut ? '0          : rs2Next;
            rd       <= clearOut ? '0          : rdNext;
            imm      <= clearOut ? '0          : immNext;
            aluOp    <= clearOut ? ADD         : aluOpNext;
            selA     <= clearOut ? 1'b0        : selANext;
            selB     <= clearOut ? SEL_B_RS2   : selBNext;
            aluToReg <= clearOut ? 1'b0        : aluToRegNext;
            memOp    <= clearOut ? MEM_DISABLE : memOpNext;
            memSize  <= clearOut ? BYTE        : memSizeNext;
            branch   <= clearOut ? 1'b0        : branchNext;
            jal      <= clearOut ? 1'b0        : jalNext;
            jalr     <= clearOut ? 1'b0        : jalrNext;
            pc       <= clearOut ? '0          : pcIn;
        end
    end

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module decodeStage (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   stall,
    input  wire logic                   flush,
    input  wire logic [`INSTR_W-1:0]    instruction,
    input  wire logic [`XLEN-1:0]       pcIn,
    output logic [`REG_ADDR_W-1:0]      rs1,
    output logic [`REG_ADDR_W-1:0]      rs2,
    output logic [`REG_ADDR_W-1:0]      rd,
    output logic [`XLEN-1:0]            imm,
    output decodePkg::aluOpT            aluOp,
    output logic                        selA,
    output decodePkg::selBT             selB,
    output logic                        aluToReg,
    output decodePkg::memOpT            memOp,
    output decodePkg::memSizeT          memSize,
    output logic                        branch,
    output logic                        jal,
    output logic                        jalr,
    output logic [`XLEN-1:0]            pc
);

    import decodePkg::*;

    // Combinational decode results
    logic [`REG_ADDR_W-1:0] rs1Next;
    logic [`REG_ADDR_W-1:0] rs2Next;
    logic [`REG_ADDR_W-1:0] rdNext;
    logic [`XLEN-1:0]       immNext;
    aluOpT                  aluOpNext;
    logic                   selANext;
    selBT                   selBNext;
    logic                   aluToRegNext;
    memOpT                  memOpNext;
    memSizeT                memSizeNext;
    logic                   branchNext;
    logic                   jalNext;
    logic                   jalrNext;
    immFmtT                 immFmt;

    ctrlDecode u_ctrlDecode (
        .instruction (instruction),
        .rs1         (rs1Next),
        .rs2         (rs2Next),
        .rd          (rdNext),
        .aluOp       (aluOpNext),
        .selA        (selANext),
        .selB        (selBNext),
        .aluToReg    (aluToRegNext),
        .memOp       (memOpNext),
        .memSize     (memSizeNext),
        .branch      (branchNext),
        .jal         (jalNext),
        .jalr        (jalrNext),
        .immFmt      (immFmt)
    );

    immGen u_immGen (
        .instruction (instruction),
        .immFmt      (immFmt),
        .imm         (immNext)
    );

    decodeReg u_decodeReg (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .flush        (flush),
        .pcIn         (pcIn),
        .rs1Next      (rs1Next),
        .rs2Next      (rs2Next),
        .rdNext       (rdNext),
        .immNext      (immNext),
        .aluOpNext    (aluOpNext),
        .selANext     (selANext),
        .selBNext     (selBNext),
        .aluToRegNext (aluToRegNext),
        .memOpNext    (memOpNext),
        .memSizeNext  (memSizeNext),
        .branchNext   (branchNext),
        .jalNext      (jalNext),
        .jalrNext     (jalrNext),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .aluOp        (aluOp),
        .selA         (selA),
        .selB         (selB),
        .aluToReg     (aluToReg),
        .memOp        (memOp),
        .memSize      (memSize),
        .branch       (branch),
        .jal          (jal),
        .jalr         (jalr),
        .pc           (pc)
    );

endmodule

`default_nettype wire

// File: decodeStage_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module decodeStageAssertions (
    input wire logic                          clk,
    input wire logic                          rstN,
    input wire logic                          stall,
    input wire logic                          flush,
    input decodePkg::memOpT                   memOp,
    input wire logic                          aluToReg,
    input wire logic                          branch,
    input wire logic                          jal,
    input wire logic                          jalr,
    input wire logic [3*`REG_ADDR_W+2*`XLEN+14:0] outState   // All registered outputs
);

    import decodePkg::*;

    int failCount = 0;

    // Reset leaves a bubble
    resetBubble: assert property (@(posedge clk) !rstN |=>
        (memOp == MEM_DISABLE && !aluToReg && !branch && !jal && !jalr))
        else begin
            failCount++;
            $error("outputs are not a bubble after reset");
        end

    oneFlowFlag: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({branch, jal, jalr}))
        else begin
            failCount++;
            $error("more than one of branch, jal and jalr is high");
        end

    memNoWriteback: assert property (@(posedge clk) disable iff (!rstN)
        (memOp != MEM_DISABLE) |-> !aluToReg)
        else begin
            failCount++;
            $error("memory operation with register writeback");
        end

    // A stalled edge holds every output
    stallHolds: assert property (@(posedge clk) disable iff (!rstN)
        (stall && !flush) |=> $stable(outState))
        else begin
            failCount++;
            $error("outputs changed on a stalled edge");
        end

endmodule

bind decodeStage decodeStageAssertions u_assertions (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (stall),
    .flush    (flush),
    .memOp    (memOp),
    .aluToReg (aluToReg),
    .branch   (branch),
    .jal      (jal),
    .jalr     (jalr),
    .outState ({rs1, rs2, rd, imm, aluOp, selA, selB, aluToReg, memOp, memSize,
                branch, jal, jalr, pc})
);

`default_nettype wire

// File: tbDecodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module tbDecodeStage;

    import decodePkg::*;

    localparam int Seed          = 11997;
    localparam int CyclesPerTest = 400;
    localparam int ResetCycles   = 10;
    localparam int WaitLimit     = 50;
    localparam int ModeAlu       = 0;
    localparam int ModeMem       = 1;
    localparam int ModeCtrl      = 2;
    localparam int ModeMixed     = 3;
    localparam int ModeBubble    = 4;

    logic        clk;
    logic        rstN;
    logic        stall;
    logic        flush;
    logic [31:0] instruction;
    logic [31:0] pcIn;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    aluOpT       aluOp;
    logic        selA;
    selBT        selB;
    logic        aluToReg;
    memOpT       memOp;
    memSizeT     memSize;
    logic        branch;
    logic        jal;
    logic        jalr;
    logic [31:0] pc;

    logic [93:0] expState;      // Model view of all outputs with pc last
    logic [93:0] actState;
    logic        expIgnore;
    logic        checking;
    logic        timedOut;
    string       testName;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          assertFails;

    decodeStage i_dut (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush),
        .instruction(instruction), .pcIn(pcIn),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
        .selA(selA), .selB(selB), .aluToReg(aluToReg), .memOp(memOp),
        .memSize(memSize), .branch(branch), .jal(jal), .jalr(jalr), .pc(pc)
    );

    assign actState = {rs1, rs2, rd, imm, aluOp, selA, selB, aluToReg,
                       memOp, memSize, branch, jal, jalr, pc};

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // RV32I funct3 table with bit 30 as alt
    function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? SUB : ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return alt ? SRA : SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    // Expected decode of one instruction without pc
    function automatic logic [61:0] decodeModel(input logic [31:0] w);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        shift;
        logic [4:0]  eRs1;
        logic [4:0]  eRs2;
        logic [4:0]  eRd;
        logic [31:0] eImm;
        aluOpT       eAlu;
        logic        eSelA;
        selBT        eSelB;
        logic        eWb;
        memOpT       eMem;
        memSizeT     eSize;
        logic [2:0]  eFlags;    // branch, jal, jalr
        f3     = w[14:12];
        f7     = w[31:25];
        shift  = (f3 == 3'd1 || f3 == 3'd5);
        eRs1   = '0;
        eRs2   = '0;
        eRd    = '0;
        eImm   = '0;
        eAlu   = ADD;
        eSelA  = 1'b0;
        eSelB  = SEL_B_RS2;
        eWb    = 1'b0;
        eMem   = MEM_DISABLE;
        eSize  = BYTE;
        eFlags = 3'b000;
        case (w[6:0])
            R_TYPE: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                {eRs1, eRs2, eRd} = {w[19:15], w[24:20], w[11:7]};
                eAlu = aluFromFunct(f3, f7[5]);
                eWb  = 1'b1;
            end
            I_TYPE: if (!shift || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
                {eRs1, eRd} = {w[19:15], w[11:7]};
                eAlu  = aluFromFunct(f3, shift && f7[5]);
                eSelB = SEL_B_IMM;
                eWb   = 1'b1;
                eImm  = shift ? {27'b0, w[24:20]} : {{20{w[31]}}, w[31:20]};
            end
            LOAD: if (f3 != 3'd3 && f3 < 3'd6) begin
                {eRs1, eRd} = {w[19:15], w[11:7]};
                eSelB = SEL_B_IMM;
                eMem  = f3[2] ? MEM_READ_ZEXT : MEM_READ_SEXT;
                eSize = memSizeT'(f3[1:0]);
                eImm  = {{20{w[31]}}, w[31:20]};
            end
            STORE: if (f3 < 3'd3) begin
                {eRs1, eRs2} = {w[19:15], w[24:20]};
                eSelB = SEL_B_IMM;
                eMem  = MEM_WRITE;
                eSize = memSizeT'(f3[1:0]);
                eImm  = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            BRANCH: if (f3 != 3'd2 && f3 != 3'd3) begin
                {eRs1, eRs2} = {w[19:15], w[24:20]};
                eFlags = 3'b100;
                eImm   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'd0:    eAlu = BEQ;
                    3'd1:    eAlu = BNE;
                    3'd4:    eAlu = BLT;
                    3'd5:    eAlu = BGE;
                    3'd6:    eAlu = BLTU;
                    default: eAlu = BGEU;
                endcase
            end
            JAL, JALR: if (w[6:0] == JAL || f3 == 3'd0) begin
                eRd    = w[11:7];
                eRs1   = (w[6:0] == JALR) ? w[19:15] : 5'd0;
                eSelA  = 1'b1;
                eSelB  = SEL_B_FOUR;   // Link value pc + 4
                eWb    = 1'b1;
                eFlags = (w[6:0] == JAL) ? 3'b010 : 3'b001;
                eImm   = (w[6:0] == JAL) ?
                         {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0} :
                         {{20{w[31]}}, w[31:20]};
            end
            LUI, AUIPC: begin
                eRd   = w[11:7];
                eSelA = (w[6:0] == AUIPC);
                eSelB = SEL_B_IMM;
                eWb   = 1'b1;
                eImm  = {w[31:12], 12'b0};
            end
            default: eWb = 1'b0;    // FENCE, SYSTEM, unknown
        endcase
        return {eRs1, eRs2, eRd, eImm, eAlu, eSelA, eSelB, eWb, eMem, eSize, eFlags};
    endfunction

    // Random instruction for one group
    // Mixed mode weights ALU, mem, ctrl and bubble as 3:3:3:1
    function automatic logic [31:0] randInstr(input int mode);
        logic [31:0] w;
        logic [2:0]  f3;
        int          grp;
        int          idx;
        w   = $urandom;
        idx = int'($urandom % 6);
        grp = (mode == ModeMixed) ? int'($urandom % 10) / 3 : mode;
        if (mode == ModeMixed && grp == 3) grp = ModeBubble;
        f3  = w[14:12];
        case (grp)
            ModeAlu: begin
                w[6:0] = (idx < 3) ? R_TYPE : I_TYPE;
                if (idx < 3 || f3 == 3'd1 || f3 == 3'd5) begin
                    w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30] &&
                                !(idx >= 3 && f3 == 3'd0)) ? 7'h20 : 7'h00;
                end
            end
            ModeMem: begin
                f3 = (idx < 3) ? 3'($urandom % 5) : 3'($urandom % 3);
                if (idx < 3 && f3 > 3'd2) f3 = f3 + 3'd1;   // LBU, LHU
                w[6:0]   = (idx < 3) ? LOAD : STORE;
                w[14:12] = f3;
            end
            ModeCtrl: begin
                f3 = 3'($urandom % 6);
                if (f3 > 3'd1) f3 = f3 + 3'd2;
                case (idx)
                    0, 1:    {w[14:12], w[6:0]} = {f3, BRANCH};
                    2:       w[6:0] = JAL;
                    3:       {w[14:12], w[6:0]} = {3'd0, JALR};
                    4:       w[6:0] = LUI;
                    default: w[6:0] = AUIPC;
                endcase
            end
            default: begin
                case (idx)
                    0:       w[6:0] = 7'b0001111;                     // FENCE
                    1:       w[6:0] = 7'b1110011;                     // SYSTEM
                    2:       w[1:0] = 2'b10;                          // Never a 32-bit opcode
                    3:       {w[14:12], w[6:0]} = {3'd3, LOAD};
                    4:       {w[14:13], w[6:0]} = {2'b01, BRANCH};
                    default: {w[31:25], w[6:0]} = {7'h01, R_TYPE};    // M extension
                endcase
            end
        endcase
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [93:0] expected,
                              input logic [93:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Reset first, then flush, then stall, then the pending discard
    always @(posedge clk) begin
        if (!rstN) begin
            expState  <= '0;
            expIgnore <= 1'b0;
        end else if (flush) begin
            expState  <= '0;
            expIgnore <= 1'b1;
        end else if (!stall) begin
            expState  <= expIgnore ? '0 : {decodeModel(instruction), pcIn};
            expIgnore <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (checking) checkValue(testName, expState, actState);
    end

    task automatic applyReset();
        int t;
        @(posedge clk);
        rstN  <= 1'b0;
        stall <= 1'b0;
        flush <= 1'b0;
        repeat (2) @(posedge clk);
        checking = 1'b1;                    // Model has seen reset by now
        repeat (ResetCycles - 2) @(posedge clk);
        rstN <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (actState !== '0 && t < WaitLimit);
        if (actState !== '0) begin
            $display("ERROR: outputs did not clear within %0d cycles of reset", WaitLimit);
            timedOut = 1'b1;
        end
    endtask

    task automatic runTest(input string name, input int mode, input int stallPct,
                           input int flushPct, input bit withReset);
        int          i;
        int          t;
        int          errBefore;
        int          checksBefore;
        logic [31:0] drainPc;
        if (!timedOut) begin
            errBefore    = errorCount;
            checksBefore = checkCount;
            testName     = name;
            if (withReset) applyReset();
            for (i = 0; i < CyclesPerTest; i++) begin
                @(posedge clk);
                instruction <= randInstr(mode);
                pcIn        <= $urandom & 32'hffff_fffc;
                stall       <= ($urandom % 100) < stallPct;
                flush       <= ($urandom % 100) < flushPct;
            end
            // Drain until the last instruction reaches the outputs
            drainPc = ($urandom & 32'hffff_fffc) | 32'h4;
            @(posedge clk);
            instruction <= randInstr(ModeAlu);
            pcIn        <= drainPc;
            stall       <= 1'b0;
            flush       <= 1'b0;
            t = 0;
            do begin
                @(negedge clk);
                t++;
            end while (pc !== drainPc && t < WaitLimit);
            if (pc !== drainPc) begin
                $display("ERROR: %s did not complete, pc never reached %h", name, drainPc);
                timedOut = 1'b1;
            end
            testCount++;
            $display("%s done: %0d checks, %0d mismatches", name,
                     checkCount - checksBefore, errorCount - errBefore);
        end
    endtask

    initial begin
        rstN        = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        instruction = '0;
        pcIn        = '0;
        checking    = 1'b0;
        timedOut    = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        testCount   = 0;
        testName    = "reset";
        void'($urandom(Seed));
        applyReset();
        runTest("aluDecode", ModeAlu, 0, 0, 1'b0);
        runTest("memDecode", ModeMem, 0, 0, 1'b0);
        runTest("ctrlFlow", ModeCtrl, 0, 0, 1'b0);
        runTest("stall", ModeMixed, 40, 0, 1'b0);
        runTest("flush", ModeMixed, 20, 10, 1'b0);
        runTest("bubbles", ModeBubble, 10, 5, 1'b1);
        assertFails = i_dut.u_assertions.failCount;
        $display("Tests: %0d, checks: %0d, mismatches: %0d, assert fails: %0d, timeouts: %0d",
                 testCount, checkCount, errorCount, assertFails, timedOut);
        if (errorCount == 0 && assertFails == 0 && !timedOut) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
decodePkg.sv
immGen.sv
ctrlDecode.sv
decodeReg.sv
decodeStage.sv
decodeStage_assertions.sv
tbDecodeStage.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tbDecodeStage
FILELIST   := files.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
RUN_ARGS   := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
